//--- design/muldiv_defines.svh
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// Width of one general purpose register operand
`define MULDIV_WORD_WIDTH 32

// One quotient bit per cycle, so this is also the divide run length
`define MULDIV_DIV_ITERATIONS 32

`endif

//--- design/muldiv_pkg.sv
`include "muldiv_defines.svh"

package muldiv_pkg;

	typedef logic [`MULDIV_WORD_WIDTH-1:0] word_t;
	typedef logic [2*`MULDIV_WORD_WIDTH-1:0] dword_t;

	typedef enum logic [3:0] {
		OP_NONE,
		OP_MULT,
		OP_MULTU,
		OP_MUL,
		OP_MADD,
		OP_MADDU,
		OP_MSUB,
		OP_MSUBU,
		OP_DIV,
		OP_DIVU
	} muldiv_op_t;

	typedef enum logic {
		DIV_IDLE,
		DIV_RUN
	} div_state_t;

	// Operand stage output with magnitudes plus the signs to restore later
	typedef struct packed {
		logic       valid;
		muldiv_op_t op;
		word_t      mag_a;
		word_t      mag_b;
		logic       negate_product;
		logic       negate_remainder;
	} prep_t;

	// Middle term carries the sum of both cross products
	typedef struct packed {
		logic                        valid;
		muldiv_op_t                  op;
		logic                        negate_product;
		word_t                       high;
		logic [`MULDIV_WORD_WIDTH:0] middle;
		word_t                       low;
	} partial_t;

	typedef struct packed {
		logic       valid;
		muldiv_op_t op;
		logic       negate_product;
		logic       negate_remainder;
		word_t      quotient;
		word_t      remainder;
	} quotient_t;

	function automatic logic is_multiply(input muldiv_op_t op);
		case (op)
			OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

endpackage

//--- design/muldiv_operand_prep.sv
`include "muldiv_defines.svh"

module muldiv_operand_prep (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   flush,
	input  logic                   start,
	input  muldiv_pkg::muldiv_op_t op,
	input  muldiv_pkg::word_t      reg_a,
	input  muldiv_pkg::word_t      reg_b,
	output muldiv_pkg::prep_t      prep
);
	import muldiv_pkg::*;

	logic  is_signed;
	logic  sign_a;
	logic  sign_b;
	word_t mag_a;
	word_t mag_b;

	// Ops that treat the register values as two's complement
	always_comb
	begin
		case (op)
			OP_MULT, OP_MUL, OP_MADD, OP_MSUB, OP_DIV:
				is_signed = 1'b1;
			default:
				is_signed = 1'b0;
		endcase
	end

	assign sign_a = is_signed & reg_a[`MULDIV_WORD_WIDTH-1];
	assign sign_b = is_signed & reg_b[`MULDIV_WORD_WIDTH-1];

	// Magnitudes feed both the multiplier and the divider
	assign mag_a = sign_a ? -reg_a : reg_a;
	assign mag_b = sign_b ? -reg_b : reg_b;

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			prep.valid <= 1'b0;
		else
			prep.valid <= start;

		if (start)
		begin
			prep.op <= op;
			prep.mag_a <= mag_a;
			prep.mag_b <= mag_b;
			// Product and quotient share the same sign rule
			prep.negate_product <= sign_a ^ sign_b;
			prep.negate_remainder <= sign_a;
		end
	end

	// Every issued op must be a real multiply or divide
	assert property (@(posedge clk) disable iff (reset)
		start |-> (is_multiply(op) || op inside {OP_DIV, OP_DIVU}))
	else
		$error("muldiv_operand_prep: start with invalid op %0d", op);

endmodule

//--- design/muldiv_multiplier.sv
`include "muldiv_defines.svh"

module muldiv_multiplier (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 flush,
	input  muldiv_pkg::prep_t    prep,
	output muldiv_pkg::partial_t partial
);
	import muldiv_pkg::*;

	localparam int WIDTH = `MULDIV_WORD_WIDTH;
	localparam int HALF = WIDTH / 2;

	logic  take;
	word_t cross_ab;
	word_t cross_ba;

	assign take = prep.valid && is_multiply(prep.op);

	// Lower half of a times upper half of b, and the other way round
	assign cross_ab = prep.mag_a[HALF-1:0] * prep.mag_b[WIDTH-1:HALF];
	assign cross_ba = prep.mag_a[WIDTH-1:HALF] * prep.mag_b[HALF-1:0];

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			partial.valid <= 1'b0;
		else
			partial.valid <= take;

		if (take)
		begin
			partial.op <= prep.op;
			partial.negate_product <= prep.negate_product;
			partial.high <= prep.mag_a[WIDTH-1:HALF] * prep.mag_b[WIDTH-1:HALF];
			// One extra bit keeps the carry of the cross sum
			partial.middle <= {1'b0, cross_ab} + {1'b0, cross_ba};
			partial.low <= prep.mag_a[HALF-1:0] * prep.mag_b[HALF-1:0];
		end
	end

endmodule

//--- design/muldiv_divider.sv
`include "muldiv_defines.svh"

module muldiv_divider (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  flush,
	input  muldiv_pkg::prep_t     prep,
	output muldiv_pkg::quotient_t quotient,
	output logic                  busy
);
	import muldiv_pkg::*;

	localparam int WIDTH = `MULDIV_WORD_WIDTH;
	localparam int ITERATIONS = `MULDIV_DIV_ITERATIONS;
	localparam int COUNT_W = $clog2(ITERATIONS + 1);

	div_state_t         state;
	logic [COUNT_W-1:0] count;
	logic               out_valid;
	logic               tail_valid;
	logic               load;
	logic               step_en;
	logic               last_step;
	word_t              divisor_q;
	word_t              rem_q;
	word_t              quo_q;
	word_t              step_divisor;
	word_t              step_rem;
	word_t              step_quo;
	logic [WIDTH:0]     shifted;
	logic [WIDTH:0]     diff;
	word_t              rem_next;
	word_t              quo_next;
	muldiv_op_t         op_q;
	logic               negate_product_q;
	logic               negate_remainder_q;

	assign load = prep.valid && (prep.op inside {OP_DIV, OP_DIVU});
	assign step_en = (state == DIV_RUN) || load;
	assign last_step = (count == COUNT_W'(ITERATIONS - 1));

	// The load cycle already produces the first quotient bit
	always_comb
	begin
		if (state == DIV_IDLE)
		begin
			step_divisor = prep.mag_b;
			step_rem = '0;
			step_quo = prep.mag_a;
		end
		else
		begin
			step_divisor = divisor_q;
			step_rem = rem_q;
			step_quo = quo_q;
		end
		shifted = {step_rem, step_quo[WIDTH-1]};
		diff = shifted - {1'b0, step_divisor};
		// Borrow out means the trial subtract is undone
		if (!diff[WIDTH])
		begin
			rem_next = diff[WIDTH-1:0];
			quo_next = {step_quo[WIDTH-2:0], 1'b1};
		end
		else
		begin
			rem_next = shifted[WIDTH-1:0];
			quo_next = {step_quo[WIDTH-2:0], 1'b0};
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			state <= DIV_IDLE;
			count <= '0;
			out_valid <= 1'b0;
			tail_valid <= 1'b0;
		end
		else
		begin
			out_valid <= 1'b0;
			// Extra cycle covers the result stage done strobe
			tail_valid <= out_valid;
			case (state)
				DIV_IDLE:
				begin
					if (load)
					begin
						state <= DIV_RUN;
						count <= COUNT_W'(1);
					end
				end
				DIV_RUN:
				begin
					count <= count + 1'b1;
					if (last_step)
					begin
						state <= DIV_IDLE;
						out_valid <= 1'b1;
					end
				end
				default:
					state <= DIV_IDLE;
			endcase
		end

		if (step_en)
		begin
			rem_q <= rem_next;
			quo_q <= quo_next;
		end

		if (state == DIV_IDLE && load)
		begin
			divisor_q <= prep.mag_b;
			op_q <= prep.op;
			negate_product_q <= prep.negate_product;
			negate_remainder_q <= prep.negate_remainder;
		end
	end

	assign quotient.valid = out_valid;
	assign quotient.op = op_q;
	assign quotient.negate_product = negate_product_q;
	assign quotient.negate_remainder = negate_remainder_q;
	assign quotient.quotient = quo_q;
	assign quotient.remainder = rem_q;

	assign busy = load || (state == DIV_RUN) || out_valid || tail_valid;

	// Issue side must wait for busy to fall before the next divide
	assert property (@(posedge clk) disable iff (reset)
		(state == DIV_RUN) |-> !load)
	else
		$error("muldiv_divider: divide arrived while running");

endmodule

//--- design/muldiv_result.sv
`include "muldiv_defines.svh"

module muldiv_result (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  flush,
	input  muldiv_pkg::partial_t  partial,
	input  muldiv_pkg::quotient_t quotient,
	output logic                  done,
	output muldiv_pkg::dword_t    result,
	output muldiv_pkg::dword_t    hilo
);
	import muldiv_pkg::*;

	localparam int HALF = `MULDIV_WORD_WIDTH / 2;

	dword_t product_mag;
	dword_t product;
	word_t  quo_signed;
	word_t  rem_signed;
	dword_t next_result;
	logic   mul_valid;
	logic   hilo_we;

	// Final carry-propagate add of the three partial products
	assign product_mag = {partial.high, partial.low} + (dword_t'(partial.middle) << HALF);
	assign product = partial.negate_product ? -product_mag : product_mag;

	// Quotient rounds toward zero and remainder follows the dividend
	assign quo_signed = quotient.negate_product ? -quotient.quotient : quotient.quotient;
	assign rem_signed = quotient.negate_remainder ? -quotient.remainder : quotient.remainder;

	assign mul_valid = partial.valid && is_multiply(partial.op);
	assign hilo_we = quotient.valid || (mul_valid && partial.op != OP_MUL);

	always_comb
	begin
		if (quotient.valid)
			next_result = {rem_signed, quo_signed};
		else
		begin
			case (partial.op)
				OP_MADD, OP_MADDU:
					next_result = hilo + product;
				OP_MSUB, OP_MSUBU:
					next_result = hilo - product;
				OP_MUL:
					next_result = dword_t'(product[`MULDIV_WORD_WIDTH-1:0]);
				default:
					next_result = product;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			done <= 1'b0;
		else
			done <= mul_valid || quotient.valid;

		if (reset)
			hilo <= '0;
		else if (hilo_we && !flush)
			hilo <= next_result;

		result <= next_result;
	end

	// A multiply issued ahead of a divide drains long before the divide ends
	assert property (@(posedge clk) disable iff (reset)
		!(partial.valid && quotient.valid))
	else
		$error("muldiv_result: multiply and divide results collided");

endmodule

//--- design/muldiv_unit.sv
module muldiv_unit (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	input  muldiv_pkg::muldiv_op_t op,
	input  muldiv_pkg::word_t      reg_a,
	input  muldiv_pkg::word_t      reg_b,
	input  logic                   flush,
	output logic                   busy,
	output logic                   done,
	output muldiv_pkg::dword_t     result,
	output muldiv_pkg::dword_t     hilo
);
	import muldiv_pkg::*;

	prep_t     prep;
	partial_t  partial;
	quotient_t quotient;

	muldiv_operand_prep u_operand_prep (
		.clk     (clk),
		.reset   (reset),
		.flush   (flush),
		.start   (start),
		.op      (op),
		.reg_a   (reg_a),
		.reg_b   (reg_b),
		.prep    (prep)
	);

	// Both back ends see every prepared op and pick out their own class
	muldiv_multiplier u_multiplier (
		.clk     (clk),
		.reset   (reset),
		.flush   (flush),
		.prep    (prep),
		.partial (partial)
	);

	muldiv_divider u_divider (
		.clk      (clk),
		.reset    (reset),
		.flush    (flush),
		.prep     (prep),
		.quotient (quotient),
		.busy     (busy)
	);

	muldiv_result u_result (
		.clk      (clk),
		.reset    (reset),
		.flush    (flush),
		.partial  (partial),
		.quotient (quotient),
		.done     (done),
		.result   (result),
		.hilo     (hilo)
	);

endmodule

//--- verification/muldiv_unit_tb.sv
`include "muldiv_defines.svh"

module muldiv_unit_tb;
	import muldiv_pkg::*;

	localparam int PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int MUL_LATENCY = 3;
	localparam int DIV_LATENCY = `MULDIV_DIV_ITERATIONS + 2;
	localparam int NUM_BURST = 24;
	localparam int NUM_ACC = 12;
	localparam int NUM_DIV = 8;
	// Idle reset window plus every op issued by the tests
	localparam int TOTAL_OPS = 4 + NUM_BURST + NUM_ACC + 1 + NUM_DIV + 6;

	// One issued op waiting for its done cycle
	typedef struct packed {
		muldiv_op_t  op;
		word_t       a;
		word_t       b;
		logic [31:0] due;
	} pending_t;

	logic        clk;
	logic        reset;
	logic        start;
	logic        flush;
	muldiv_op_t  op;
	word_t       reg_a;
	word_t       reg_b;
	logic        busy;
	logic        done;
	dword_t      result;
	dword_t      hilo;

	pending_t    pend[$];
	logic [31:0] cyc;
	logic        exp_done;
	logic        exp_busy;
	dword_t      exp_result;
	dword_t      exp_hilo;
	logic        div_active;
	logic [31:0] div_issue;
	logic        flush_pending;
	integer      seed;
	int          error_count;
	int          test_errors;
	int          pass_count;
	int          fail_count;
	string       test_name;

	muldiv_unit u_dut (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.op     (op),
		.reg_a  (reg_a),
		.reg_b  (reg_b),
		.flush  (flush),
		.busy   (busy),
		.done   (done),
		.result (result),
		.hilo   (hilo)
	);

	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk)
	begin
		if (reset)
			cyc <= '0;
		else
			cyc <= cyc + 32'd1;
	end

	// Architectural result of one op given the HI/LO value it sees
	function automatic dword_t expected_value(input pending_t p, input dword_t old_hilo);
		longint sa;
		longint sb;
		dword_t ua;
		dword_t ub;
		sa = longint'($signed(p.a));
		sb = longint'($signed(p.b));
		ua = {32'b0, p.a};
		ub = {32'b0, p.b};
		case (p.op)
			OP_MULT:
				return dword_t'(sa * sb);
			OP_MULTU:
				return ua * ub;
			OP_MUL:
				return {32'b0, 32'(sa * sb)};
			OP_MADD:
				return old_hilo + dword_t'(sa * sb);
			OP_MADDU:
				return old_hilo + ua * ub;
			OP_MSUB:
				return old_hilo - dword_t'(sa * sb);
			OP_MSUBU:
				return old_hilo - ua * ub;
			// Remainder in HI, quotient in LO
			OP_DIV:
				return {32'(sa % sb), 32'(sa / sb)};
			OP_DIVU:
				return {32'(ua % ub), 32'(ua / ub)};
			default:
				return '0;
		endcase
	endfunction

	task automatic update_model();
		pending_t p;
		// A flush seen on the last edge kills everything still in flight
		if (flush_pending)
		begin
			pend.delete();
			div_active = 1'b0;
			flush_pending = 1'b0;
		end
		exp_done = 1'b0;
		if (pend.size() > 0 && pend[0].due == cyc)
		begin
			p = pend.pop_front();
			exp_done = 1'b1;
			exp_result = expected_value(p, exp_hilo);
			if (p.op != OP_MUL)
				exp_hilo = exp_result;
		end
		exp_busy = div_active && cyc > div_issue && cyc <= div_issue + DIV_LATENCY;
	endtask

	task automatic tick();
		@(negedge clk);
		update_model();
		start = 1'b0;
		flush = 1'b0;
	endtask

	task automatic issue(input muldiv_op_t issue_op, input word_t a, input word_t b);
		pending_t p;
		logic is_div;
		tick();
		is_div = issue_op inside {OP_DIV, OP_DIVU};
		p.op = issue_op;
		p.a = a;
		p.b = b;
		p.due = cyc + (is_div ? DIV_LATENCY : MUL_LATENCY);
		pend.push_back(p);
		if (is_div)
		begin
			div_active = 1'b1;
			div_issue = cyc;
		end
		start = 1'b1;
		op = issue_op;
		reg_a = a;
		reg_b = b;
	endtask

	task automatic flush_now();
		tick();
		flush = 1'b1;
		flush_pending = 1'b1;
	endtask

	task automatic drain();
		while (pend.size() > 0)
			tick();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = error_count;
	endtask

	task automatic end_test();
		drain();
		// Let the checks see the final cycle
		tick();
		if (error_count == test_errors)
		begin
			pass_count++;
			$display("Test %s: passed", test_name);
		end
		else
		begin
			fail_count++;
			$display("Test %s: failed with %0d errors", test_name, error_count - test_errors);
		end
	endtask

	function automatic word_t rand_word();
		return word_t'($random(seed));
	endfunction

	// Never zero and with the top bit clear so a sign can be applied afterwards
	function automatic word_t rand_magnitude(input int max_shift);
		word_t w;
		int shift;
		shift = 1 + int'((32'($random(seed)) & 32'h7fff_ffff) % max_shift);
		w = rand_word() >> shift;
		if (w == '0)
			w = 32'd1;
		return w;
	endfunction

	assert property (@(posedge clk) disable iff (reset) done === exp_done)
	else
	begin
		error_count++;
		$display("Error at time %0t: done = %0b, expected %0b",
			$time, $sampled(done), $sampled(exp_done));
	end

	assert property (@(posedge clk) disable iff (reset) busy === exp_busy)
	else
	begin
		error_count++;
		$display("Error at time %0t: busy = %0b, expected %0b",
			$time, $sampled(busy), $sampled(exp_busy));
	end

	assert property (@(posedge clk) disable iff (reset) hilo === exp_hilo)
	else
	begin
		error_count++;
		$display("Error at time %0t: hilo = %h, expected %h",
			$time, $sampled(hilo), $sampled(exp_hilo));
	end

	assert property (@(posedge clk) disable iff (reset) !exp_done || result === exp_result)
	else
	begin
		error_count++;
		$display("Error at time %0t: result = %h, expected %h",
			$time, $sampled(result), $sampled(exp_result));
	end

	initial
	begin
		#((TOTAL_OPS * DIV_LATENCY + RESET_CYCLES + 100) * PERIOD);
		$display("Error: watchdog timeout, the tests did not finish in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		word_t a;
		word_t b;
		seed = 54;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		flush = 1'b0;
		op = OP_NONE;
		reg_a = '0;
		reg_b = '0;
		exp_done = 1'b0;
		exp_busy = 1'b0;
		exp_result = '0;
		exp_hilo = '0;
		div_active = 1'b0;
		div_issue = '0;
		flush_pending = 1'b0;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		repeat (RESET_CYCLES) tick();
		reset = 1'b0;

		begin_test("reset state");
		repeat (4) tick();
		end_test();

		begin_test("multiply burst");
		for (int i = 0; i < NUM_BURST; i++)
			issue((i % 3 == 0) ? OP_MULT : (i % 3 == 1) ? OP_MULTU : OP_MUL,
				rand_word(), rand_word());
		end_test();

		begin_test("accumulate chain");
		issue(OP_MULT, rand_word(), rand_word());
		for (int i = 0; i < NUM_ACC; i++)
			issue((i % 4 == 0) ? OP_MADD : (i % 4 == 1) ? OP_MADDU :
				(i % 4 == 2) ? OP_MSUB : OP_MSUBU, rand_word(), rand_word());
		end_test();

		// Low bits pick the operand signs and bit 2 picks unsigned
		begin_test("divide");
		for (int i = 0; i < NUM_DIV; i++)
		begin
			a = rand_magnitude(4);
			b = rand_magnitude(24);
			if (i[0])
				a = -a;
			if (i[1])
				b = -b;
			issue(i[2] ? OP_DIVU : OP_DIV, a, b);
			drain();
		end
		end_test();

		begin_test("flush");
		issue(OP_DIV, rand_magnitude(4), rand_magnitude(24));
		repeat (10) tick();
		flush_now();
		issue(OP_MULT, rand_word(), rand_word());
		drain();
		issue(OP_MADD, rand_word(), rand_word());
		issue(OP_MSUB, rand_word(), rand_word());
		flush_now();
		issue(OP_MADDU, rand_word(), rand_word());
		issue(OP_DIVU, rand_word(), rand_magnitude(24));
		end_test();

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- muldiv_unit.f
+incdir+design
design/muldiv_pkg.sv
design/muldiv_operand_prep.sv
design/muldiv_multiplier.sv
design/muldiv_divider.sv
design/muldiv_result.sv
design/muldiv_unit.sv
verification/muldiv_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module muldiv_unit_tb \
	-f muldiv_unit.f -o muldiv_sim
./obj_dir/muldiv_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log || ! grep -q "Simulation finished: PASS" sim.log; then
	exit 1
fi
